// File: Makefile
# Verilator build, run, lint and clean for the instruction cache

TOP := icache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "TEST FAILED" sim.log; then exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module icache_top

clean:
	rm -rf obj_dir sim.log

// File: dv/icache_chk.sv
// Handshake and reset assertions for the instruction cache, bound to icache_top

`timescale 1ns/1ps

`default_nettype none

module icache_chk
(
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      fetch_ready_i,
  input  wire                      resp_valid_i,
  input  wire  icache_pkg::instr_t resp_instr_i,
  input  wire                      resp_ready_i,
  input  wire                      req_valid_i,
  input  wire  icache_pkg::addr_t  req_addr_i,
  input  wire                      req_ready_i
);

  // Block requests are 16-byte aligned
  a_req_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> (req_addr_i[3:0] == 4'h0))
    else $error("Block request address is not block aligned");

  // Held response while the consumer stalls
  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_instr_i))
    else $error("Response dropped or changed while stalled");

  a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_addr_i))
    else $error("Block request dropped or changed while stalled");

  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !fetch_ready_i && !resp_valid_i && !req_valid_i)
    else $error("Outputs not low in the cycle after reset");

endmodule

bind icache_top icache_chk chk_i
(
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .fetch_ready_i (fetch_ready_o),
  .resp_valid_i  (resp_valid_o),
  .resp_instr_i  (resp_instr_o),
  .resp_ready_i  (resp_ready_i),
  .req_valid_i   (mem_req_valid_o),
  .req_addr_i    (mem_req_addr_o),
  .req_ready_i   (mem_req_ready_i)
);

`default_nettype wire

// File: dv/icache_tb.sv
// Instruction cache testbench
// Table-driven fetch stream, block memory model, response and request checks

`timescale 1ns/1ps

`include "icache_cfg.svh"

`default_nettype none

module icache_tb;

  typedef struct packed
  {
    icache_pkg::addr_t addr;
    logic [3:0]        stall;
  } row_t;

  localparam int num_rows = 27;
  localparam int wait_limit = 200;

  // Fetch address, then cycles of resp_ready_i low once the response shows
  localparam row_t rows [num_rows] = '{
    '{32'h0000_1000, 4'd0}, '{32'h0000_1008, 4'd0}, '{32'h0000_100C, 4'd0},
    '{32'h0000_1004, 4'd2}, '{32'h0000_1400, 4'd0}, '{32'h0000_1000, 4'd0},
    '{32'h0000_1404, 4'd0}, '{32'h0000_1008, 4'd0}, '{32'h0000_1800, 4'd0},
    '{32'h0000_100C, 4'd0}, '{32'h0000_1408, 4'd0}, '{32'h0000_1004, 4'd0},
    '{32'h0000_1000, 4'd4}, '{32'h0000_2010, 4'd3}, '{32'h0000_3020, 4'd0},
    '{32'h0000_3034, 4'd0}, '{32'h0000_3048, 4'd0}, '{32'h0000_3024, 4'd0},
    '{32'h0000_2014, 4'd0}, '{32'h0000_3038, 4'd0}, '{32'h0000_304C, 4'd0},
    '{32'h0000_1008, 4'd0}, '{32'h0000_140C, 4'd0}, '{32'h0000_302C, 4'd2},
    '{32'h0000_3800, 4'd0}, '{32'h0000_1000, 4'd0}, '{32'h0000_3804, 4'd0}
  };

  logic               clk_i = 1'b0;
  logic               reset_i;
  logic               fetch_valid_i;
  icache_pkg::addr_t  fetch_addr_i;
  logic               fetch_ready_o;
  logic               resp_valid_o;
  icache_pkg::instr_t resp_instr_o;
  logic               resp_ready_i;
  logic               mem_req_valid_o;
  icache_pkg::addr_t  mem_req_addr_o;
  logic               mem_req_ready_i;
  logic               fill_valid_i;
  icache_pkg::block_t fill_data_i;
  logic               fill_ready_o;

  // Expected block request per row, filled in by the reference model
  logic               row_req [num_rows];
  int                 exp_requests;

  // Memory model state
  icache_pkg::addr_t  req_q [$];
  int                 req_count;
  logic               mem_busy;
  int                 mem_delay;
  icache_pkg::addr_t  mem_addr;

  always #4 clk_i = ~clk_i;

  icache_top icache_top_i
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_instr_o    (resp_instr_o),
    .resp_ready_i    (resp_ready_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_ready_i (mem_req_ready_i),
    .fill_valid_i    (fill_valid_i),
    .fill_data_i     (fill_data_i),
    .fill_ready_o    (fill_ready_o)
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // Instruction k of block B is (B + 4k) XOR C0DE0000
  function automatic icache_pkg::block_t fill_block(icache_pkg::addr_t base);
    icache_pkg::block_t blk;
    for (int k = 0; k < 4; k++)
      blk[32*k +: 32] = (base + 32'(4*k)) ^ 32'hC0DE_0000;
    return blk;
  endfunction

  // Plain model of tags, valid bits and one LRU bit per set
  function automatic void predict_requests();
    icache_pkg::tag_t tag_m [`ICACHE_WAYS][`ICACHE_SETS];
    logic             valid_m [`ICACHE_WAYS][`ICACHE_SETS];
    logic             lru_m [`ICACHE_SETS];
    logic [5:0]       idx;
    logic [21:0]      tag;
    logic [1:0]       hit;
    for (int s = 0; s < `ICACHE_SETS; s++)
    begin
      valid_m[0][s] = 1'b0;
      valid_m[1][s] = 1'b0;
      lru_m[s] = 1'b0;
    end
    exp_requests = 0;
    for (int i = 0; i < num_rows; i++)
    begin
      idx = rows[i].addr[9:4];
      tag = rows[i].addr[31:10];
      for (int w = 0; w < 2; w++)
        hit[w] = valid_m[w][idx] && (tag_m[w][idx] == tag);
      row_req[i] = (hit == 2'b00);
      if (hit[0])
        lru_m[idx] = 1'b1;
      else if (hit[1])
        lru_m[idx] = 1'b0;
      else
      begin
        // Fill the victim way, then point at the other one
        tag_m[lru_m[idx]][idx] = tag;
        valid_m[lru_m[idx]][idx] = 1'b1;
        lru_m[idx] = ~lru_m[idx];
        exp_requests++;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Block memory model with random request ready and fill delay
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    void'($urandom(32'h5828f484));
    mem_req_ready_i = 1'b0;
    fill_valid_i = 1'b0;
    fill_data_i = '0;
    mem_busy = 1'b0;
    mem_delay = 0;
    mem_addr = '0;
    req_count = 0;
    forever
    begin
      @(negedge clk_i);
      // Fill channel open exactly while a block is owed
      check_value("fill_ready_o", 32'(fill_ready_o), 32'(mem_busy));
      mem_req_ready_i = ($urandom % 3) != 0;
      fill_valid_i = mem_busy && (mem_delay == 0);
      fill_data_i = fill_block(mem_addr);
      if (mem_busy && mem_delay != 0)
        mem_delay--;
      // Transfers taken at the coming rising edge
      if (fill_valid_i && fill_ready_o)
        mem_busy = 1'b0;
      if (mem_req_valid_o && mem_req_ready_i)
      begin
        req_q.push_back(mem_req_addr_o);
        req_count++;
        mem_busy = 1'b1;
        mem_addr = mem_req_addr_o;
        mem_delay = $urandom % 6;
      end
    end
  end

  // Drives each row and holds it until accepted
  task automatic issue_rows();
    int waited;
    for (int i = 0; i < num_rows; i++)
    begin
      @(negedge clk_i);
      fetch_valid_i = 1'b1;
      fetch_addr_i = rows[i].addr;
      waited = 0;
      // Look once the falling-edge inputs have settled
      #1;
      while (fetch_ready_o !== 1'b1)
      begin
        waited++;
        if (waited > wait_limit)
          abort_run($sformatf("Timed out waiting for fetch_ready_o on row %0d", i));
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
  endtask

  // Takes responses in row order, stalling where the table says
  task automatic collect_rows();
    int                 waited;
    icache_pkg::instr_t held;
    icache_pkg::instr_t exp_instr;
    for (int i = 0; i < num_rows; i++)
    begin
      @(negedge clk_i);
      resp_ready_i = (rows[i].stall == 4'd0);
      waited = 0;
      while (resp_valid_o !== 1'b1)
      begin
        waited++;
        if (waited > wait_limit)
          abort_run($sformatf("Timed out waiting for resp_valid_o on row %0d", i));
        @(negedge clk_i);
      end
      held = resp_instr_o;
      for (int c = 0; c < int'(rows[i].stall); c++)
      begin
        @(negedge clk_i);
        check_value("resp_valid_o", 32'(resp_valid_o), 32'h1);
        check_value("resp_instr_o", resp_instr_o, held);
        check_value("fetch_ready_o", 32'(fetch_ready_o), 32'h0);
      end
      resp_ready_i = 1'b1;
      exp_instr = (rows[i].addr & 32'hFFFF_FFFC) ^ 32'hC0DE_0000;
      check_value("resp_instr_o", resp_instr_o, exp_instr);
      if (row_req[i])
      begin
        if (req_q.size() == 0)
          abort_run($sformatf("Row %0d missed but no block request was seen", i));
        check_value("mem_req_addr_o", req_q.pop_front(), rows[i].addr & 32'hFFFF_FFF0);
      end
    end
  endtask

  initial
  begin
    reset_i = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i = '0;
    resp_ready_i = 1'b1;
    predict_requests();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // First cycle out of reset
    check_value("resp_valid_o", 32'(resp_valid_o), 32'h0);
    check_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'h0);
    check_value("fetch_ready_o", 32'(fetch_ready_o), 32'h0);
    fork
      issue_rows();
      collect_rows();
    join
    check_value("block request count", 32'(req_count), 32'(exp_requests));
    check_value("unmatched block requests", 32'(req_q.size()), 32'h0);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/icache_cfg.svh
// Geometry of the two-way instruction cache
// Set count, associativity and the block, instruction and address widths

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Number of sets, one index per 16-byte block
`define ICACHE_SETS 64

// Ways per set
`define ICACHE_WAYS 2

// One block is four instructions
`define ICACHE_BLOCK_BITS 128

// Fetch granule
`define ICACHE_INSTR_BITS 32

// Physical byte address
`define ICACHE_ADDR_BITS 32

`endif

// File: source/icache_data_array.sv
// Block storage, one SRAM-shaped memory per way
// Both ways read together, a fill writes one way

`timescale 1ns/1ps

`include "icache_cfg.svh"

`default_nettype none

module icache_data_array
(
  input  wire                                         clk_i,
  input  wire                                         rd_en_i,
  input  wire  icache_pkg::index_t                    rd_index_i,
  output icache_pkg::block_t [`ICACHE_WAYS-1:0]       rd_block_o,
  input  wire                                         wr_en_i,
  input  wire  icache_pkg::index_t                    wr_index_i,
  input  wire  icache_pkg::way_t                      wr_way_i,
  input  wire  icache_pkg::block_t                    wr_block_i
);

  for (genvar w = 0; w < `ICACHE_WAYS; w++)
  begin : g_way
    icache_pkg::block_t mem [`ICACHE_SETS];
    icache_pkg::block_t rd_q;
    logic               way_wr;

    assign way_wr = wr_en_i & (wr_way_i == icache_pkg::way_t'(w));

    // Read data held until the next read
    always_ff @(posedge clk_i)
    begin
      if (way_wr)
        mem[wr_index_i] <= wr_block_i;
      if (rd_en_i)
        rd_q <= mem[rd_index_i];
    end

    assign rd_block_o[w] = rd_q;
  end

endmodule

`default_nettype wire

// File: source/icache_lru.sv
// Replacement state, one bit per set naming the next victim way

`timescale 1ns/1ps

`include "icache_cfg.svh"

`default_nettype none

module icache_lru
(
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      rd_en_i,
  input  wire  icache_pkg::index_t rd_index_i,
  output icache_pkg::way_t         victim_o,
  input  wire                      touch_en_i,
  input  wire  icache_pkg::index_t touch_index_i,
  input  wire  icache_pkg::way_t   touch_way_i
);

  logic [`ICACHE_SETS-1:0] lru_r;
  logic                    same_set;

  // A touch on the set being read wins over the stored bit
  assign same_set = touch_en_i & (touch_index_i == rd_index_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lru_r <= '0;
      victim_o <= '0;
    end
    else
    begin
      if (rd_en_i)
        victim_o <= same_set ? ~touch_way_i : lru_r[rd_index_i];
      // Point away from the way just used
      if (touch_en_i)
        lru_r[touch_index_i] <= ~touch_way_i;
    end
  end

endmodule

`default_nettype wire

// File: source/icache_miss_ctrl.sv
// Miss controller FSM
// Sends the block request, writes the fill and hands the block back

`timescale 1ns/1ps

`include "icache_cfg.svh"

`default_nettype none

module icache_miss_ctrl
(
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      miss_i,
  input  wire  icache_pkg::addr_t  miss_addr_i,
  input  wire  icache_pkg::way_t   victim_i,
  output logic                     mem_req_valid_o,
  output icache_pkg::addr_t        mem_req_addr_o,
  input  wire                      mem_req_ready_i,
  input  wire                      fill_valid_i,
  input  wire  icache_pkg::block_t fill_data_i,
  output logic                     fill_ready_o,
  output logic                     fill_wr_en_o,
  output icache_pkg::index_t       fill_index_o,
  output icache_pkg::way_t         fill_way_o,
  output icache_pkg::tag_t         fill_tag_o,
  output icache_pkg::block_t       fill_block_o,
  output logic                     fill_done_o
);

  icache_pkg::miss_state_e state_r;
  icache_pkg::miss_state_e state_n;
  icache_pkg::addr_t       miss_addr_r;
  icache_pkg::way_t        victim_r;
  icache_pkg::block_t      block_r;
  logic                    fill_done_r;
  logic                    miss_take;
  logic                    fill_fire;

  assign miss_take = miss_i & (state_r == icache_pkg::e_idle);
  assign fill_fire = fill_valid_i & fill_ready_o;

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      icache_pkg::e_idle:
        if (miss_i)
          state_n = icache_pkg::e_request;
      icache_pkg::e_request:
        if (mem_req_ready_i)
          state_n = icache_pkg::e_fill;
      icache_pkg::e_fill:
        if (fill_valid_i)
          state_n = icache_pkg::e_idle;
      default:
        state_n = icache_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= icache_pkg::e_idle;
      fill_done_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      fill_done_r <= fill_fire;
    end
  end

  // Miss context and returned block
  always_ff @(posedge clk_i)
  begin
    if (miss_take)
    begin
      miss_addr_r <= miss_addr_i;
      victim_r <= victim_i;
    end
    if (fill_fire)
      block_r <= fill_data_i;
  end

  assign mem_req_valid_o = (state_r == icache_pkg::e_request);
  assign mem_req_addr_o = icache_pkg::block_addr(miss_addr_r);
  assign fill_ready_o = (state_r == icache_pkg::e_fill);

  // Fill write lands at the transfer edge
  assign fill_wr_en_o = fill_fire;
  assign fill_index_o = icache_pkg::addr_index(miss_addr_r);
  assign fill_tag_o = icache_pkg::addr_tag(miss_addr_r);
  assign fill_way_o = victim_r;
  assign fill_block_o = block_r;
  assign fill_done_o = fill_done_r;

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
// Field types and address helpers shared by the instruction cache
// Also holds the miss-controller state encoding

`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  localparam int instr_offset_bits = $clog2(`ICACHE_INSTR_BITS / 8);
  localparam int offset_bits = $clog2(`ICACHE_BLOCK_BITS / 8);
  localparam int index_bits = $clog2(`ICACHE_SETS);
  localparam int tag_bits = `ICACHE_ADDR_BITS - index_bits - offset_bits;
  localparam int word_sel_bits = $clog2(`ICACHE_BLOCK_BITS / `ICACHE_INSTR_BITS);
  localparam int way_bits = $clog2(`ICACHE_WAYS);

  typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [word_sel_bits-1:0] word_sel_t;
  typedef logic [`ICACHE_BLOCK_BITS-1:0] block_t;
  typedef logic [`ICACHE_INSTR_BITS-1:0] instr_t;
  typedef logic [way_bits-1:0] way_t;

  typedef enum logic [1:0]
  {
    e_idle,
    e_request,
    e_fill
  } miss_state_e;

  // Address field extraction
  function automatic index_t addr_index(addr_t addr);
    return addr[offset_bits +: index_bits];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[offset_bits + index_bits +: tag_bits];
  endfunction

  function automatic word_sel_t addr_word(addr_t addr);
    return addr[instr_offset_bits +: word_sel_bits];
  endfunction

  function automatic addr_t block_addr(addr_t addr);
    return {addr[`ICACHE_ADDR_BITS-1:offset_bits], {offset_bits{1'b0}}};
  endfunction

endpackage

`default_nettype wire

// File: source/icache_tag_array.sv
// Tag and valid storage for every way of the cache
// Synchronous read of one set, single-way fill write

`timescale 1ns/1ps

`include "icache_cfg.svh"

`default_nettype none

module icache_tag_array
(
  input  wire                                         clk_i,
  input  wire                                         reset_i,
  input  wire                                         rd_en_i,
  input  wire  icache_pkg::index_t                    rd_index_i,
  output icache_pkg::tag_t [`ICACHE_WAYS-1:0]         rd_tag_o,
  output logic [`ICACHE_WAYS-1:0]                     rd_valid_o,
  input  wire                                         wr_en_i,
  input  wire  icache_pkg::index_t                    wr_index_i,
  input  wire  icache_pkg::way_t                      wr_way_i,
  input  wire  icache_pkg::tag_t                      wr_tag_i
);

  // Tag memory per way
  icache_pkg::tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];

  // One valid bit per line
  logic [`ICACHE_SETS-1:0] valid_r [`ICACHE_WAYS];

  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      tag_mem[wr_way_i][wr_index_i] <= wr_tag_i;
    if (rd_en_i)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
        rd_tag_o[w] <= tag_mem[w][rd_index_i];
    end
  end

  // Valid bits and their read port
  // Outputs stay put until the next read so a stalled lookup keeps them
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
        valid_r[w] <= '0;
      rd_valid_o <= '0;
    end
    else
    begin
      if (rd_en_i)
      begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
          rd_valid_o[w] <= valid_r[w][rd_index_i];
      end
      if (wr_en_i)
        valid_r[wr_way_i][wr_index_i] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/icache_top.sv
// Two-way set-associative instruction cache top
// Lookup pipeline, tag compare, word select, response hold and array instances

`timescale 1ns/1ps

`include "icache_cfg.svh"

`default_nettype none

module icache_top
(
  input  wire                      clk_i,
  input  wire                      reset_i,
  // Fetch
  input  wire                      fetch_valid_i,
  input  wire  icache_pkg::addr_t  fetch_addr_i,
  output logic                     fetch_ready_o,
  // Response
  output logic                     resp_valid_o,
  output icache_pkg::instr_t       resp_instr_o,
  input  wire                      resp_ready_i,
  // Block request
  output logic                     mem_req_valid_o,
  output icache_pkg::addr_t        mem_req_addr_o,
  input  wire                      mem_req_ready_i,
  // Fill
  input  wire                      fill_valid_i,
  input  wire  icache_pkg::block_t fill_data_i,
  output logic                     fill_ready_o
);

  icache_pkg::tag_t [`ICACHE_WAYS-1:0]   rd_tag;
  logic [`ICACHE_WAYS-1:0]               rd_valid;
  icache_pkg::block_t [`ICACHE_WAYS-1:0] rd_block;
  icache_pkg::way_t                      victim;

  logic                ready_r;
  logic                lk_valid_r;
  icache_pkg::addr_t   lk_addr_r;
  logic                lk_filled_r;
  logic                miss_pend_r;
  logic                resp_valid_r;
  icache_pkg::instr_t  resp_instr_r;

  logic [`ICACHE_WAYS-1:0] hit_vec;
  icache_pkg::way_t        hit_way;
  icache_pkg::block_t      hit_block;
  icache_pkg::block_t      src_block;
  icache_pkg::instr_t      lk_word;
  logic                    lk_hit;
  logic                    fill_sel;
  logic                    fetch_fire;
  logic                    resp_free;
  logic                    lk_go;
  logic                    miss;

  logic                    fill_wr_en;
  icache_pkg::index_t      fill_index;
  icache_pkg::way_t        fill_way;
  icache_pkg::tag_t        fill_tag;
  icache_pkg::block_t      fill_block;
  logic                    fill_done;

  logic                    touch_en;
  icache_pkg::index_t      touch_index;
  icache_pkg::way_t        touch_way;

  //////////////////////////////////////////////////////////////////////////
  // Tag compare and word select on the lookup stage
  //////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    hit_vec = '0;
    hit_way = '0;
    hit_block = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      hit_vec[w] = rd_valid[w] & (rd_tag[w] == icache_pkg::addr_tag(lk_addr_r));
      if (hit_vec[w])
        hit_way = icache_pkg::way_t'(w);
      // One-hot AND-OR way mux
      hit_block = hit_block | (rd_block[w] & {`ICACHE_BLOCK_BITS{hit_vec[w]}});
    end
  end

  assign lk_hit = |hit_vec;

  // Once the fill has come back the word comes from the fill block
  assign fill_sel = lk_filled_r | fill_done;
  assign src_block = fill_sel ? fill_block : hit_block;
  assign lk_word = src_block[icache_pkg::addr_word(lk_addr_r) * `ICACHE_INSTR_BITS +:
                             `ICACHE_INSTR_BITS];

  //////////////////////////////////////////////////////////////////////////
  // Pipeline control
  //////////////////////////////////////////////////////////////////////////
  assign resp_free = ~resp_valid_r | resp_ready_i;
  assign lk_go = lk_valid_r & resp_free & (lk_hit | fill_sel);
  assign fetch_ready_o = ready_r & resp_free & (~lk_valid_r | lk_hit);
  assign fetch_fire = fetch_valid_i & fetch_ready_o;
  assign miss = lk_valid_r & ~lk_hit & ~miss_pend_r & ~lk_filled_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      ready_r <= 1'b0;
      lk_valid_r <= 1'b0;
      lk_filled_r <= 1'b0;
      miss_pend_r <= 1'b0;
      resp_valid_r <= 1'b0;
    end
    else
    begin
      ready_r <= 1'b1;
      if (fetch_fire)
        lk_valid_r <= 1'b1;
      else if (lk_go)
        lk_valid_r <= 1'b0;
      // Fill came back while the response slot was still busy
      if (lk_go)
        lk_filled_r <= 1'b0;
      else if (fill_done)
        lk_filled_r <= 1'b1;
      if (miss)
        miss_pend_r <= 1'b1;
      else if (fill_done)
        miss_pend_r <= 1'b0;
      if (lk_go)
        resp_valid_r <= 1'b1;
      else if (resp_ready_i)
        resp_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_fire)
      lk_addr_r <= fetch_addr_i;
    if (lk_go)
      resp_instr_r <= lk_word;
  end

  assign resp_valid_o = resp_valid_r;
  assign resp_instr_o = resp_instr_r;

  // Fills and hits both refresh the replacement bit
  assign touch_en = fill_wr_en | (lk_go & ~fill_sel);
  assign touch_index = fill_wr_en ? fill_index : icache_pkg::addr_index(lk_addr_r);
  assign touch_way = fill_wr_en ? fill_way : hit_way;

  //////////////////////////////////////////////////////////////////////////
  // Arrays and miss controller
  //////////////////////////////////////////////////////////////////////////
  icache_tag_array tag_array_i
  (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_en_i    (fetch_fire),
    .rd_index_i (icache_pkg::addr_index(fetch_addr_i)),
    .rd_tag_o   (rd_tag),
    .rd_valid_o (rd_valid),
    .wr_en_i    (fill_wr_en),
    .wr_index_i (fill_index),
    .wr_way_i   (fill_way),
    .wr_tag_i   (fill_tag)
  );

  icache_data_array data_array_i
  (
    .clk_i      (clk_i),
    .rd_en_i    (fetch_fire),
    .rd_index_i (icache_pkg::addr_index(fetch_addr_i)),
    .rd_block_o (rd_block),
    .wr_en_i    (fill_wr_en),
    .wr_index_i (fill_index),
    .wr_way_i   (fill_way),
    .wr_block_i (fill_data_i)
  );

  icache_lru lru_i
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_en_i       (fetch_fire),
    .rd_index_i    (icache_pkg::addr_index(fetch_addr_i)),
    .victim_o      (victim),
    .touch_en_i    (touch_en),
    .touch_index_i (touch_index),
    .touch_way_i   (touch_way)
  );

  icache_miss_ctrl miss_ctrl_i
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_i          (miss),
    .miss_addr_i     (lk_addr_r),
    .victim_i        (victim),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_ready_i (mem_req_ready_i),
    .fill_valid_i    (fill_valid_i),
    .fill_data_i     (fill_data_i),
    .fill_ready_o    (fill_ready_o),
    .fill_wr_en_o    (fill_wr_en),
    .fill_index_o    (fill_index),
    .fill_way_o      (fill_way),
    .fill_tag_o      (fill_tag),
    .fill_block_o    (fill_block),
    .fill_done_o     (fill_done)
  );

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_lru.sv
source/icache_miss_ctrl.sv
source/icache_top.sv
dv/icache_chk.sv
dv/icache_tb.sv
